/* rtl/sdramPkg.sv */
package sdramPkg;

    // **************************************************
    // Device geometry of the 16-bit SDR part
    // **************************************************
    localparam int BankBits = 2;
    localparam int RowBits  = 13;                           // Also the width of the address pins
    localparam int ColBits  = 10;
    localparam int DataBits = 16;
    localparam int BurstLen = 8;                            // Words per read or write burst

    // Encoded as the {RAS_N, CAS_N, WE_N} pin triple
    typedef enum logic [2:0] {
        CMD_LOADMODE  = 3'b000,
        CMD_REFRESH   = 3'b001,
        CMD_PRECHARGE = 3'b010,
        CMD_ACTIVE    = 3'b011,
        CMD_WRITE     = 3'b100,
        CMD_READ      = 3'b101,
        CMD_NOP       = 3'b111
    } sdramCmd;

    // Everything the controller drives towards the device pins
    typedef struct packed {
        logic                cke;
        logic                csN;
        sdramCmd             cmd;
        logic [BankBits-1:0] ba;
        logic [RowBits-1:0]  addr;
        logic [1:0]          dqm;                           // Byte masks, low during transfers
        logic [DataBits-1:0] dqOut;
        logic                dqOe;                          // High while the controller owns DQ
    } sdramBus;

endpackage

/* rtl/burstTestPkg.sv */
package burstTestPkg;

    // One burst request from the sequencer to the controller
    typedef struct packed {
        logic [sdramPkg::BankBits-1:0] bank;
        logic [sdramPkg::RowBits-1:0]  row;
        logic [sdramPkg::ColBits-1:0]  col;
        logic                          isRead;
    } burstReq;

    // One returned word, valid for a single cycle
    typedef struct packed {
        logic                          valid;
        logic [sdramPkg::DataBits-1:0] data;
    } readWord;

    typedef enum logic [2:0] {IDLE, FILL, WRITE_WAIT, READ_WAIT, DONE} seqState;

    // Targets cover all four banks, with shared rows in banks 0, 1 and 2
    function automatic burstReq targetTable(input logic [2:0] index);
        burstReq target;
        case (index)
            3'd0:    target = '{bank: 2'd0, row: 13'd0, col: 10'd0, isRead: 1'b0};
            3'd1:    target = '{bank: 2'd0, row: 13'd0, col: 10'd8, isRead: 1'b0};
            3'd2:    target = '{bank: 2'd0, row: 13'd1, col: 10'd40, isRead: 1'b0};
            3'd3:    target = '{bank: 2'd1, row: 13'd1, col: 10'd40, isRead: 1'b0};
            3'd4:    target = '{bank: 2'd1, row: 13'd1, col: 10'd16, isRead: 1'b0};
            3'd5:    target = '{bank: 2'd2, row: 13'd5, col: 10'd8, isRead: 1'b0};
            3'd6:    target = '{bank: 2'd2, row: 13'd5, col: 10'd24, isRead: 1'b0};
            default: target = '{bank: 2'd3, row: 13'd2, col: 10'd16, isRead: 1'b0};
        endcase
        return target;
    endfunction

    // Upper byte tags the target, lower byte tags the position in the burst
    function automatic logic [15:0] patternWord(input logic [2:0] index,
                                                input logic [2:0] pos);
        return {8'(index) * 8'h11, 8'hA0 + 8'(pos)};
    endfunction

endpackage

/* rtl/burstTestSequencer.sv */
`timescale 1ns/1ps

module burstTestSequencer (
    input  logic                  Clock,
    input  logic                  rst,
    input  logic                  busy,
    input  burstTestPkg::readWord rdWord,
    input  logic [3:0]            wordCount,
    output logic                  pushWord,
    output logic [15:0]           pushData,
    output logic                  reqStrobe,
    output burstTestPkg::burstReq req,
    output logic                  done,
    output logic [7:0]            errorCount
);
    import sdramPkg::*;
    import burstTestPkg::*;

    seqState    state;
    logic [4:0] target;                                     // 0 to 7 write, 8 to 15 read back
    logic [2:0] wordCnt;                                    // Position inside the current burst
    logic       issueReq;
    logic       mismatch;

    // Push while filling, as long as the buffer has room
    assign pushWord = (state == FILL) && (wordCount != 4'(BurstLen));
    assign pushData = patternWord(target[2:0], wordCnt);

    // A new strobe only once the previous one has been seen as busy
    assign issueReq = !busy && !reqStrobe &&
                      ((state == WRITE_WAIT) || (state == IDLE && target[4:3] == 2'b01));

    assign mismatch = rdWord.data != patternWord(target[2:0], wordCnt);

    // **************************************************
    // Test flow
    // **************************************************
    always_ff @(posedge Clock) begin
        if (rst) begin
            state      <= IDLE;
            target     <= '0;
            wordCnt    <= '0;
            reqStrobe  <= 1'b0;
            done       <= 1'b0;
            errorCount <= '0;
        end else begin
            reqStrobe <= issueReq;                          // One cycle pulse
            case (state)
                IDLE: begin
                    if (target == 5'd16) begin
                        state <= DONE;
                    end else if (!target[3]) begin
                        state <= FILL;
                    end else if (issueReq) begin
                        state <= READ_WAIT;
                    end
                end
                FILL: begin
                    if (pushWord) begin
                        wordCnt <= wordCnt + 3'd1;
                        if (wordCnt == 3'(BurstLen - 1)) begin
                            state <= WRITE_WAIT;
                        end
                    end
                end
                WRITE_WAIT: begin
                    if (issueReq) begin
                        target <= target + 5'd1;
                        state  <= IDLE;                     // Next burst is staged while this one runs
                    end
                end
                READ_WAIT: begin
                    if (rdWord.valid) begin
                        wordCnt <= wordCnt + 3'd1;
                        if (mismatch && errorCount != 8'hFF) begin
                            errorCount <= errorCount + 8'd1;
                        end
                        if (wordCnt == 3'(BurstLen - 1)) begin
                            target <= target + 5'd1;
                            state  <= IDLE;
                        end
                    end
                end
                default: done <= 1'b1;
            endcase
        end
    end

    // Request fields follow the strobe
    always_ff @(posedge Clock) begin
        if (issueReq) begin
            req        <= targetTable(target[2:0]);
            req.isRead <= target[3];
        end
    end

endmodule

/* rtl/burstDataBuffer.sv */
`timescale 1ns/1ps

module burstDataBuffer (
    input  logic        Clock,
    input  logic        rst,
    input  logic        pushWord,
    input  logic [15:0] pushData,
    input  logic        popWord,
    output logic [15:0] popData,
    output logic [3:0]  wordCount
);
    import sdramPkg::*;

    localparam int PtrBits = $clog2(BurstLen);

    logic [15:0]        mem [BurstLen];
    logic [PtrBits-1:0] wrPtr;
    logic [PtrBits-1:0] rdPtr;
    logic               doPush;
    logic               doPop;

    // Pushing into a full buffer or popping an empty one does nothing
    assign doPush = pushWord && (wordCount != 4'(BurstLen));
    assign doPop  = popWord && (wordCount != 4'd0);

    assign popData = mem[rdPtr];                            // Head word is visible before the pop

    always_ff @(posedge Clock) begin
        if (rst) begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            wordCount <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            wordCount <= wordCount + 4'(doPush) - 4'(doPop);
        end
    end

    always_ff @(posedge Clock) begin
        if (doPush) begin
            mem[wrPtr] <= pushData;
        end
    end

endmodule

/* rtl/sdramBurstCtrl.sv */
`timescale 1ns/1ps

module sdramBurstCtrl #(
    parameter int CasLatency      = 2,
    parameter int RefreshInterval = 780,
    parameter int InitCycles      = 13300,
    parameter int TrcdCycles      = 2
) (
    input  logic                  Clock,
    input  logic                  rst,
    input  logic                  reqStrobe,
    input  burstTestPkg::burstReq req,
    input  logic [15:0]           popData,
    input  logic [15:0]           dramDqIn,
    output logic                  busy,
    output logic                  popWord,
    output burstTestPkg::readWord rdWord,
    output sdramPkg::sdramBus     dramBus
);
    import sdramPkg::*;
    import burstTestPkg::*;

    localparam int RefWidth = $clog2(RefreshInterval + 1);

    typedef enum logic [2:0] {
        INIT, IDLE, ACTIVATE, RCD_WAIT, WRITE_BURST, READ_BURST, PRECHARGE_WAIT, REFRESH
    } ctrlState;

    ctrlState              state;
    burstReq               reqLatch;
    logic [2:0]            initStep;
    logic [15:0]           waitCount;
    logic [15:0]           initWait;
    logic [2:0]            beatCount;
    logic                  lastRcd;
    logic                  readBeat;
    logic [12:0]           modeWord;
    logic [RefWidth-1:0]   refreshCount;
    logic                  refreshPending;
    logic [CasLatency-1:0] capShift;
    logic                  rdValid;
    logic [15:0]           rdData;

    // Burst length 8, sequential, programmed CAS latency, burst writes
    assign modeWord = {3'b000, 1'b0, 2'b00, 3'(CasLatency), 1'b0, 3'b011};

    // The power-up wait is long, the gaps between init commands are short
    assign initWait = (initStep == 3'd0) ? 16'(InitCycles - 1) : 16'd7;

    assign lastRcd  = (state == RCD_WAIT) && (waitCount == 16'(TrcdCycles - 1));
    assign readBeat = (state == READ_BURST);

    // The first word leaves the buffer together with the WRITE command
    assign popWord = (lastRcd && !reqLatch.isRead) ||
                     (state == WRITE_BURST && beatCount != 3'(BurstLen - 1));

    // **************************************************
    // Command state machine and pin register
    // **************************************************
    always_ff @(posedge Clock) begin
        if (rst) begin
            state     <= INIT;
            initStep  <= '0;
            waitCount <= '0;
            beatCount <= '0;
            busy      <= 1'b1;
            dramBus   <= '{cke: 1'b1, csN: 1'b0, cmd: CMD_NOP, default: '0};
        end else begin
            dramBus.cmd <= CMD_NOP;                         // Every command lasts one cycle
            waitCount   <= waitCount + 16'd1;
            if (popWord) begin
                dramBus.dqOut <= popData;
            end
            case (state)
                INIT: begin
                    if (waitCount == initWait) begin
                        waitCount <= '0;
                        initStep  <= initStep + 3'd1;
                        case (initStep)
                            3'd0: begin
                                dramBus.cmd  <= CMD_PRECHARGE;
                                dramBus.addr <= 13'h0400;   // A10 high closes all banks
                            end
                            3'd1, 3'd2: dramBus.cmd <= CMD_REFRESH;
                            3'd3: begin
                                dramBus.cmd  <= CMD_LOADMODE;
                                dramBus.ba   <= '0;
                                dramBus.addr <= modeWord;
                            end
                            default: begin
                                state <= IDLE;
                                busy  <= 1'b0;
                            end
                        endcase
                    end
                end
                IDLE: begin
                    if (reqStrobe) begin
                        busy  <= 1'b1;
                        state <= ACTIVATE;
                    end else if (refreshPending) begin
                        dramBus.cmd <= CMD_REFRESH;
                        busy        <= 1'b1;
                        waitCount   <= '0;
                        state       <= REFRESH;
                    end
                end
                ACTIVATE: begin
                    dramBus.cmd  <= CMD_ACTIVE;
                    dramBus.ba   <= reqLatch.bank;
                    dramBus.addr <= reqLatch.row;
                    waitCount    <= '0;
                    state        <= RCD_WAIT;
                end
                RCD_WAIT: begin
                    if (lastRcd) begin
                        dramBus.cmd  <= reqLatch.isRead ? CMD_READ : CMD_WRITE;
                        dramBus.addr <= {2'b00, 1'b1, reqLatch.col};  // A10 for auto-precharge
                        dramBus.dqOe <= !reqLatch.isRead;
                        beatCount    <= '0;
                        state        <= reqLatch.isRead ? READ_BURST : WRITE_BURST;
                    end
                end
                WRITE_BURST, READ_BURST: begin
                    beatCount <= beatCount + 3'd1;
                    if (beatCount == 3'(BurstLen - 1)) begin
                        dramBus.dqOe <= 1'b0;
                        waitCount    <= '0;
                        state        <= PRECHARGE_WAIT;
                    end
                end
                PRECHARGE_WAIT: begin
                    if (waitCount == 16'd1) begin
                        busy  <= 1'b0;
                        state <= IDLE;
                    end
                end
                default: begin
                    if (waitCount == 16'd7) begin          // Refresh holds busy for 8 cycles
                        busy  <= 1'b0;
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge Clock) begin
        if (state == IDLE && reqStrobe) begin
            reqLatch <= req;
        end
    end

    // **************************************************
    // Refresh timer, restarted by every REFRESH on the pins
    // **************************************************
    always_ff @(posedge Clock) begin
        if (rst || dramBus.cmd == CMD_REFRESH) begin
            refreshCount   <= '0;
            refreshPending <= 1'b0;
        end else if (refreshCount == RefWidth'(RefreshInterval - 1)) begin
            refreshPending <= 1'b1;                         // Served once the burst ends
        end else begin
            refreshCount <= refreshCount + 1'b1;
        end
    end

    // Read data arrives CasLatency cycles after each READ beat
    always_ff @(posedge Clock) begin
        if (rst) begin
            capShift <= '0;
            rdValid  <= 1'b0;
        end else begin
            capShift <= {capShift[CasLatency-2:0], readBeat};
            rdValid  <= capShift[CasLatency-1];
        end
    end

    always_ff @(posedge Clock) begin
        rdData <= dramDqIn;
    end

    assign rdWord = '{valid: rdValid, data: rdData};

endmodule

/* rtl/sdramBurstTop.sv */
`timescale 1ns/1ps

module sdramBurstTop #(
    parameter int CasLatency      = 2,
    parameter int RefreshInterval = 780,
    parameter int InitCycles      = 13300,
    parameter int TrcdCycles      = 2
) (
    input  logic              Clock,
    input  logic              rst,
    input  logic [15:0]       dramDqIn,
    output sdramPkg::sdramBus dramBus,
    output logic              done,
    output logic [7:0]        errorCount
);
    import burstTestPkg::*;

    logic        pushWord;
    logic [15:0] pushData;
    logic        popWord;
    logic [15:0] popData;
    logic [3:0]  wordCount;
    logic        busy;
    logic        reqStrobe;
    burstReq     req;
    readWord     rdWord;

    burstTestSequencer sequencer (
        .Clock      (Clock),
        .rst        (rst),
        .busy       (busy),
        .rdWord     (rdWord),
        .wordCount  (wordCount),
        .pushWord   (pushWord),
        .pushData   (pushData),
        .reqStrobe  (reqStrobe),
        .req        (req),
        .done       (done),
        .errorCount (errorCount)
    );

    burstDataBuffer dataBuffer (
        .Clock     (Clock),
        .rst       (rst),
        .pushWord  (pushWord),
        .pushData  (pushData),
        .popWord   (popWord),
        .popData   (popData),
        .wordCount (wordCount)
    );

    sdramBurstCtrl #(
        .CasLatency      (CasLatency),
        .RefreshInterval (RefreshInterval),
        .InitCycles      (InitCycles),
        .TrcdCycles      (TrcdCycles)
    ) burstCtrl (
        .Clock     (Clock),
        .rst       (rst),
        .reqStrobe (reqStrobe),
        .req       (req),
        .popData   (popData),
        .dramDqIn  (dramDqIn),
        .busy      (busy),
        .popWord   (popWord),
        .rdWord    (rdWord),
        .dramBus   (dramBus)
    );

endmodule

/* testbench/sdramModel.sv */
`timescale 1ns/1ps

module sdramModel #(
    parameter int CasLatency = 2
) (
    input  logic              Clock,
    input  logic              rst,
    input  sdramPkg::sdramBus dramBus,
    input  logic              corrupt,
    output logic [15:0]       dramDqIn
);
    import sdramPkg::*;

    logic [15:0] mem [int];                                 // Sparse storage keyed by bank, row, col
    logic [12:0] openRow [4];
    logic [1:0]  wrBank;
    logic [12:0] wrRow;
    logic [9:0]  wrCol;
    logic [1:0]  rdBank;
    logic [12:0] rdRow;
    logic [9:0]  rdCol;
    logic [15:0] word;
    logic [3:0]  flipBit;
    int          wrSlot;
    int          rdSlot;
    int          rdCount;
    int          flipIndex;
    int          seed = 24825;

    function automatic int wordAddr(input logic [1:0] bank, input logic [12:0] row,
                                    input logic [9:0] col);
        return int'({7'd0, bank, row, col});
    endfunction

    initial begin
        dramDqIn = '0;
        wrSlot   = BurstLen;
        rdSlot   = -1;
        rdCount  = 0;
    end

    always @(posedge Clock) begin
        if (rst) begin
            wrSlot    = BurstLen;
            rdSlot    = -1;
            rdCount   = 0;
            flipIndex = int'($unsigned($random(seed)) % 64);  // One of the 64 read words
            flipBit   = 4'($random(seed));
            dramDqIn <= '0;
        end else begin
            if (rdSlot >= 0) rdSlot = rdSlot + 1;
            if (wrSlot < BurstLen) wrSlot = wrSlot + 1;
            case (dramBus.cmd)
                CMD_ACTIVE: openRow[dramBus.ba] = dramBus.addr;
                CMD_WRITE: begin
                    wrBank = dramBus.ba;
                    wrRow  = openRow[dramBus.ba];
                    wrCol  = dramBus.addr[9:0];
                    wrSlot = 0;                             // First word rides with the command
                end
                CMD_READ: begin
                    rdBank = dramBus.ba;
                    rdRow  = openRow[dramBus.ba];
                    rdCol  = dramBus.addr[9:0];
                    rdSlot = 0;
                end
                default: ;
            endcase

            if (wrSlot < BurstLen && dramBus.dqOe) begin
                mem[wordAddr(wrBank, wrRow, wrCol + 10'(wrSlot))] = dramBus.dqOut;
            end

            // Drive each word one cycle early so it is stable at the latency edge
            if (rdSlot >= CasLatency - 1 && rdSlot < CasLatency - 1 + BurstLen) begin
                word = 16'h0000;
                if (mem.exists(wordAddr(rdBank, rdRow, rdCol + 10'(rdSlot - CasLatency + 1))))
                    word = mem[wordAddr(rdBank, rdRow, rdCol + 10'(rdSlot - CasLatency + 1))];
                if (corrupt && rdCount == flipIndex) begin
                    word = word ^ (16'd1 << flipBit);       // Single bit fault
                end
                rdCount = rdCount + 1;
                dramDqIn <= word;
            end else if (rdSlot >= CasLatency - 1 + BurstLen) begin
                rdSlot = -1;
            end
        end
    end

endmodule

/* testbench/sdramBurstTb.sv */
`timescale 1ns/1ps

module sdramBurstTb;
    import sdramPkg::*;

    localparam int CasLatency      = 2;
    localparam int RefreshInterval = 300;
    localparam int InitCycles      = 50;
    localparam int TrcdCycles      = 2;
    localparam int BurstCycles     = 16;                    // ACTIVE, tRCD, 8 beats, precharge, slack
    localparam int MaxCycles       = 6000;

    logic        Clock;
    logic        rst;
    logic        corrupt;
    logic [15:0] dramDqIn;
    sdramBus     dramBus;
    logic        done;
    logic [7:0]  errorCount;

    // Write targets in table order
    logic [1:0]  tgtBank [8] = '{2'd0, 2'd0, 2'd0, 2'd1, 2'd1, 2'd2, 2'd2, 2'd3};
    logic [12:0] tgtRow  [8] = '{13'd0, 13'd0, 13'd1, 13'd1, 13'd1, 13'd5, 13'd5, 13'd2};
    logic [9:0]  tgtCol  [8] = '{10'd0, 10'd8, 10'd40, 10'd40, 10'd16, 10'd8, 10'd24, 10'd16};

    int          errors = 0;
    int          cycleCount = 0;
    int          runIndex = 0;
    logic        rstSeen = 1'b0;
    int          sinceReset;
    int          initIdx;
    int          sinceActive;
    int          sinceRefresh;
    int          writeCount;
    int          readCount;
    int          beatReg;
    logic        doneSeen;
    logic [12:0] activeRow;
    logic        isWrite;
    logic        isRead;
    logic        isActive;
    logic        isRefresh;
    int          curPos;
    int          curTarget;
    logic [2:0]  burstIdx;

    sdramBurstTop #(
        .CasLatency      (CasLatency),
        .RefreshInterval (RefreshInterval),
        .InitCycles      (InitCycles),
        .TrcdCycles      (TrcdCycles)
    ) uut (
        .Clock      (Clock),
        .rst        (rst),
        .dramDqIn   (dramDqIn),
        .dramBus    (dramBus),
        .done       (done),
        .errorCount (errorCount)
    );

    sdramModel #(.CasLatency(CasLatency)) model (
        .Clock    (Clock),
        .rst      (rst),
        .dramBus  (dramBus),
        .corrupt  (corrupt),
        .dramDqIn (dramDqIn)
    );

    initial begin
        Clock = 1'b0;
        forever #10 Clock = ~Clock;
    end

    function automatic logic [15:0] expectedWord(input int target, input int pos);
        return {8'(target * 17), 8'(160 + pos)};            // Target times 0x11, 0xA0 plus position
    endfunction

    function automatic sdramCmd initCmd(input int step);
        if (step == 0) return CMD_PRECHARGE;
        if (step == 3) return CMD_LOADMODE;
        return CMD_REFRESH;
    endfunction

    task automatic reportMismatch(input string name, input logic [15:0] expected,
                                  input logic [15:0] actual);
        errors++;
        $display("FAIL t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
    endtask

    task automatic reportFault(input string what);
        errors++;
        $display("Error at %0t: %s", $time, what);
    endtask

    // **************************************************
    // Bus trackers
    // **************************************************
    assign isWrite   = dramBus.cmd == CMD_WRITE;
    assign isRead    = dramBus.cmd == CMD_READ;
    assign isActive  = dramBus.cmd == CMD_ACTIVE;
    assign isRefresh = dramBus.cmd == CMD_REFRESH;
    assign curPos    = isWrite ? 0 : beatReg;
    assign curTarget = isWrite ? writeCount : writeCount - 1;
    assign burstIdx  = 3'(isWrite ? writeCount : readCount);

    always @(posedge Clock) begin
        rstSeen <= rst;
        if (rst) begin
            sinceReset   <= 0;
            initIdx      <= 0;
            sinceActive  <= 1000;
            sinceRefresh <= 0;
            writeCount   <= 0;
            readCount    <= 0;
            beatReg      <= 0;
            doneSeen     <= 1'b0;
        end else begin
            sinceReset   <= sinceReset + 1;
            sinceActive  <= isActive ? 1 : sinceActive + 1;
            sinceRefresh <= isRefresh ? 1 : sinceRefresh + 1;
            if (dramBus.cmd != CMD_NOP && initIdx < 4) initIdx <= initIdx + 1;
            if (isActive) activeRow <= dramBus.addr;
            if (isWrite) writeCount <= writeCount + 1;
            if (isRead) readCount <= readCount + 1;
            if (dramBus.dqOe) beatReg <= curPos + 1;
            if (done) doneSeen <= 1'b1;
        end
    end

    // **************************************************
    // Checks
    // **************************************************
    assert property (@(posedge Clock) rstSeen |-> dramBus.cmd == CMD_NOP)
        else reportMismatch("cmd", 16'(CMD_NOP), 16'(dramBus.cmd));
    assert property (@(posedge Clock) rstSeen |-> !dramBus.dqOe)
        else reportMismatch("dqOe", 16'd0, 16'(dramBus.dqOe));
    assert property (@(posedge Clock) rstSeen |-> !done)
        else reportMismatch("done", 16'd0, 16'(done));
    assert property (@(posedge Clock) rstSeen |-> errorCount == 8'd0)
        else reportMismatch("errorCount", 16'd0, 16'(errorCount));

    assert property (@(posedge Clock) disable iff (rst)
            (dramBus.cmd != CMD_NOP && initIdx == 0) |-> sinceReset >= InitCycles)
        else reportFault($sformatf("first command came after only %0d cycles", sinceReset));
    assert property (@(posedge Clock) disable iff (rst)
            (dramBus.cmd != CMD_NOP && initIdx < 4) |-> dramBus.cmd == initCmd(initIdx))
        else reportMismatch("init cmd", 16'(initCmd(initIdx)), 16'(dramBus.cmd));
    assert property (@(posedge Clock) disable iff (rst)
            (dramBus.cmd == CMD_PRECHARGE && initIdx == 0) |-> dramBus.addr[10])
        else reportMismatch("addr[10]", 16'd1, 16'(dramBus.addr[10]));
    assert property (@(posedge Clock) disable iff (rst)
            dramBus.cmd == CMD_LOADMODE |-> dramBus.addr[6:0] == {3'(CasLatency), 1'b0, 3'b011})
        else reportMismatch("mode", 16'({3'(CasLatency), 1'b0, 3'b011}),
                            16'(dramBus.addr[6:0]));

    assert property (@(posedge Clock) disable iff (rst)
            (isWrite || isRead) |-> sinceActive == TrcdCycles)
        else reportFault($sformatf("burst command %0d cycles after ACTIVE", sinceActive));
    assert property (@(posedge Clock) disable iff (rst) isWrite |-> writeCount < 8)
        else reportFault("more than eight write bursts");
    assert property (@(posedge Clock) disable iff (rst)
            (isWrite || isRead) |-> dramBus.ba == tgtBank[burstIdx])
        else reportMismatch("ba", 16'(tgtBank[burstIdx]), 16'(dramBus.ba));
    assert property (@(posedge Clock) disable iff (rst)
            (isWrite || isRead) |-> activeRow == tgtRow[burstIdx])
        else reportMismatch("row", 16'(tgtRow[burstIdx]), 16'(activeRow));
    assert property (@(posedge Clock) disable iff (rst)
            (isWrite || isRead) |-> dramBus.addr[10:0] == {1'b1, tgtCol[burstIdx]})
        else reportMismatch("addr", 16'({1'b1, tgtCol[burstIdx]}), 16'(dramBus.addr[10:0]));
    assert property (@(posedge Clock) disable iff (rst)
            dramBus.dqOe |-> dramBus.dqOut == expectedWord(curTarget, curPos))
        else reportMismatch("dqOut", expectedWord(curTarget, curPos), dramBus.dqOut);
    assert property (@(posedge Clock) disable iff (rst) dramBus.dqOe |-> curPos < 8)
        else reportFault("write burst drove more than eight words");

    assert property (@(posedge Clock) disable iff (rst)
            (isRefresh && initIdx == 4) |-> sinceRefresh <= RefreshInterval + BurstCycles)
        else reportFault($sformatf("refresh gap of %0d cycles", sinceRefresh));
    assert property (@(posedge Clock) disable iff (rst) isActive |-> sinceRefresh >= 8)
        else reportFault("ACTIVE during a refresh");

    assert property (@(posedge Clock) disable iff (rst)
            (done && !doneSeen) |-> errorCount == 8'(runIndex))
        else reportMismatch("errorCount", 16'(runIndex), 16'(errorCount));
    assert property (@(posedge Clock) disable iff (rst) doneSeen |-> !isActive)
        else reportFault("ACTIVE issued after done");

    // **************************************************
    // Stimulus
    // **************************************************
    task automatic startRun(input int run, input logic fault);
        rst      <= 1'b1;
        corrupt  <= fault;
        runIndex <= run;                                    // Run 1 expects one flipped word
        repeat (2) @(posedge Clock);
        rst <= 1'b0;
    endtask

    task automatic waitForDoneAndRefresh();
        while (!done) @(posedge Clock);
        // The periodic refresh comes after done, stray ACTIVE commands are watched meanwhile
        while (!isRefresh) @(posedge Clock);
        repeat (2) @(posedge Clock);
    endtask

    always @(posedge Clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= MaxCycles) begin
            $display("Timeout: run did not finish within %0d cycles, errors %0d",
                     MaxCycles, errors);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        rst     = 1'b1;
        corrupt = 1'b0;
        startRun(0, 1'b0);
        waitForDoneAndRefresh();
        startRun(1, 1'b1);
        waitForDoneAndRefresh();
        $display("Checks done: %0d errors, %0d cycles", errors, cycleCount);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* flist.f */
rtl/sdramPkg.sv
rtl/burstTestPkg.sv
rtl/burstTestSequencer.sv
rtl/burstDataBuffer.sv
rtl/sdramBurstCtrl.sv
rtl/sdramBurstTop.sv
testbench/sdramModel.sv
testbench/sdramBurstTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = sdramBurstTb
FLIST     = flist.f
BUILD     = obj_dir
PASS_MSG  = Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)
